// ==== hw/kbd_pkg.sv ====
`default_nettype none

package kbd_pkg;

  // axi4-lite widths on the core side
  localparam int AXI_ADDR_W = 4;
  localparam int AXI_DATA_W = 32;

  // one key event, from the keyboard line to the core
  typedef struct packed {
    // scan-code byte with prefixes stripped
    logic [7:0] code;
    // byte came after 0xE0
    logic       extended;
    // byte came after 0xF0, key went up
    logic       released;
    // start, stop or parity check failed
    logic       error;
  } kbd_event_t;

  // prefix bytes folded into the following event
  localparam logic [7:0] KBD_PREFIX_EXT = 8'hE0;
  localparam logic [7:0] KBD_PREFIX_REL = 8'hF0;

  // register offsets

  // data: valid in bit 31, event in the low bits, read pops
  localparam logic [AXI_ADDR_W-1:0] KBD_REG_DATA   = 4'h0;
  // status: empty in bit 8, level in the low bits
  localparam logic [AXI_ADDR_W-1:0] KBD_REG_STATUS = 4'h4;
  // ctrl: receiver enable in bit 0
  localparam logic [AXI_ADDR_W-1:0] KBD_REG_CTRL   = 4'h8;
  // errcnt: popped events with error set, any write clears
  localparam logic [AXI_ADDR_W-1:0] KBD_REG_ERRCNT = 4'hC;

  // axi response codes
  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== hw/kbd_fifo_rd_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface kbd_fifo_rd_if
  import kbd_pkg::*;
#(
  parameter int FIFO_DEPTH_LOG2 = 4
) ();

  // head of the fifo, valid while empty is low
  kbd_event_t               rd_data;
  logic                     empty;
  // stored events, one bit wider than the address
  logic [FIFO_DEPTH_LOG2:0] level;
  // take the head, rd_data moves on the next cycle
  logic                     pop;

  // storage side
  modport fifo (input pop, output rd_data, empty, level);
  // register block side
  modport ctrl (output pop, input rd_data, empty, level);

endinterface

`default_nettype wire

// ==== hw/kbd_frame_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module kbd_frame_rx
  import kbd_pkg::*;
(
  input  logic       kbd_clk,
  input  logic       rst,
  input  logic       kbd_data,
  input  logic       enable,
  output logic       push,
  output kbd_event_t push_data,
  input  logic       full
);

  logic [1:0] rst_sync;
  logic       rst_kc;
  logic [1:0] en_sync;
  logic [3:0] bit_cnt;
  logic [8:0] shift_reg;
  logic       frame_en;
  logic       ext_pend;
  logic       rel_pend;
  logic       frame_done;
  logic       frame_err;
  logic [7:0] code;
  logic       is_prefix;

  // core reset into the keyboard domain
  always_ff @(posedge kbd_clk) begin
    rst_sync <= {rst_sync[0], rst};
  end

  assign rst_kc = rst_sync[1];

  // enable bit from the register block, two flops
  always_ff @(posedge kbd_clk) begin
    if (rst_kc) begin
      en_sync <= '0;
    end else begin
      en_sync <= {en_sync[0], enable};
    end
  end

  // 0 is idle, 1..8 data bits, 9 parity, 10 stop
  always_ff @(posedge kbd_clk) begin
    if (rst_kc) begin
      bit_cnt  <= '0;
      frame_en <= 1'b0;
    end else if (bit_cnt == 4'd0) begin
      // first low sample on an idle line is the start bit
      if (!kbd_data) begin
        bit_cnt  <= 4'd1;
        // enable is judged once per frame, at its start
        frame_en <= en_sync[1];
      end
    end else if (bit_cnt == 4'd10) begin
      bit_cnt <= '0;
    end else begin
      bit_cnt <= bit_cnt + 4'd1;
    end
  end

  // data lsb first then parity, shifted in from the top
  always_ff @(posedge kbd_clk) begin
    if (bit_cnt != 4'd0 && bit_cnt != 4'd10) begin
      shift_reg <= {kbd_data, shift_reg[8:1]};
    end
  end

  // the stop bit is on the line while the counter sits at 10
  assign frame_done = (bit_cnt == 4'd10);
  assign code       = shift_reg[7:0];

  // stop must be 1, data plus parity must hold an odd count of ones
  assign frame_err  = !kbd_data || !(^shift_reg);
  assign is_prefix  = !frame_err && (code == KBD_PREFIX_EXT || code == KBD_PREFIX_REL);

  // event goes out on the edge that samples the stop bit
  // dropped if the fifo is full, the line is never held
  assign push = frame_done && frame_en && !is_prefix && !full;

  // an errored byte carries no prefix flags
  always_comb begin
    push_data.code     = code;
    push_data.extended = ext_pend && !frame_err;
    push_data.released = rel_pend && !frame_err;
    push_data.error    = frame_err;
  end

  // prefix flags wait for the next plain byte
  always_ff @(posedge kbd_clk) begin
    if (rst_kc) begin
      ext_pend <= 1'b0;
      rel_pend <= 1'b0;
    end else if (frame_done && frame_en) begin
      if (frame_err) begin
        ext_pend <= 1'b0;
        rel_pend <= 1'b0;
      end else if (code == KBD_PREFIX_EXT) begin
        ext_pend <= 1'b1;
      end else if (code == KBD_PREFIX_REL) begin
        rel_pend <= 1'b1;
      end else begin
        // plain byte used the flags, pushed or lost
        ext_pend <= 1'b0;
        rel_pend <= 1'b0;
      end
    end
  end

  // a frame is 11 samples, counter never runs past the stop bit
  a_bit_cnt_range: assert property (
    @(posedge kbd_clk) disable iff (rst_kc)
    bit_cnt <= 4'd10
  );

endmodule

`default_nettype wire

// ==== hw/kbd_gray_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module kbd_gray_fifo
  import kbd_pkg::*;
#(
  parameter type payload_t       = kbd_event_t,
  parameter int  FIFO_DEPTH_LOG2 = 4
) (
  input  logic        wr_clk,
  input  logic        rst,
  input  logic        push,
  input  payload_t    push_data,
  output logic        full,
  input  logic        rd_clk,
  kbd_fifo_rd_if.fifo rd
);

  localparam int AW    = FIFO_DEPTH_LOG2;
  localparam int DEPTH = 1 << AW;

  payload_t    mem [DEPTH];
  logic [1:0]  wr_rst_sync;
  logic        wr_rst;
  logic [AW:0] wr_bin;
  logic [AW:0] wr_bin_next;
  logic [AW:0] wr_gray;
  logic [AW:0] rd_gray_wq1;
  logic [AW:0] rd_gray_wq2;
  logic [AW:0] rd_bin;
  logic [AW:0] rd_bin_next;
  logic [AW:0] rd_gray;
  logic [AW:0] wr_gray_rq1;
  logic [AW:0] wr_gray_rq2;
  logic [AW:0] wr_bin_rq;

  function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
    logic [AW:0] b;
    b[AW] = g[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // write side, keyboard clock

  // reset comes from the core domain
  always_ff @(posedge wr_clk) begin
    wr_rst_sync <= {wr_rst_sync[0], rst};
  end

  assign wr_rst      = wr_rst_sync[1];
  assign wr_bin_next = wr_bin + (AW + 1)'(push && !full);

  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      wr_bin      <= '0;
      wr_gray     <= '0;
      rd_gray_wq1 <= '0;
      rd_gray_wq2 <= '0;
    end else begin
      wr_bin      <= wr_bin_next;
      wr_gray     <= wr_bin_next ^ (wr_bin_next >> 1);
      rd_gray_wq1 <= rd_gray;
      rd_gray_wq2 <= rd_gray_wq1;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (push && !full) begin
      mem[wr_bin[AW-1:0]] <= push_data;
    end
  end

  // full when the pointers differ only in the two top gray bits
  assign full = (wr_gray == {~rd_gray_wq2[AW:AW-1], rd_gray_wq2[AW-2:0]});

  // read side, core clock
  assign rd_bin_next = rd_bin + (AW + 1)'(rd.pop && !rd.empty);

  always_ff @(posedge rd_clk) begin
    if (rst) begin
      rd_bin      <= '0;
      rd_gray     <= '0;
      wr_gray_rq1 <= '0;
      wr_gray_rq2 <= '0;
    end else begin
      rd_bin      <= rd_bin_next;
      rd_gray     <= rd_bin_next ^ (rd_bin_next >> 1);
      wr_gray_rq1 <= wr_gray;
      wr_gray_rq2 <= wr_gray_rq1;
    end
  end

  assign wr_bin_rq  = gray2bin(wr_gray_rq2);
  assign rd.empty   = (rd_gray == wr_gray_rq2);
  // level lags pushes by the synchronizer delay
  assign rd.level   = wr_bin_rq - rd_bin;
  assign rd.rd_data = mem[rd_bin[AW-1:0]];

  a_no_pop_empty: assert property (
    @(posedge rd_clk) disable iff (rst)
    rd.pop |-> !rd.empty
  );

  // write pointer must reach the read side one gray step at a time
  a_gray_step: assert property (
    @(posedge rd_clk) disable iff (rst)
    $countones(wr_gray_rq2 ^ $past(wr_gray_rq2)) <= 1
  );

endmodule

`default_nettype wire

// ==== hw/kbd_axil_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module kbd_axil_regs
  import kbd_pkg::*;
#(
  parameter int FIFO_DEPTH_LOG2 = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  // write address and data
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic [3:0]            wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  // write response
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  // read address and data
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [AXI_DATA_W-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  kbd_fifo_rd_if.ctrl           fifo,
  output logic                  enable
);

  logic                  aw_hs;
  logic                  ar_hs;
  logic                  wr_ok;
  logic                  rd_ok;
  logic                  err_clear;
  logic [AXI_DATA_W-1:0] rd_word;
  logic [AXI_DATA_W-1:0] err_cnt;

  // both sides see valid and ready on the same edge
  assign aw_hs = awvalid && awready && wvalid && wready;
  assign ar_hs = arvalid && arready;

  // only ctrl and errcnt take writes
  assign wr_ok     = (awaddr == KBD_REG_CTRL) || (awaddr == KBD_REG_ERRCNT);
  assign err_clear = aw_hs && (awaddr == KBD_REG_ERRCNT);

  // write channel: ready for one cycle, then response until bready
  always_ff @(posedge clk) begin
    if (rst) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= 1'b0;
      wready  <= 1'b0;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (aw_hs) begin
        bvalid <= 1'b1;
      end else if (awvalid && wvalid && !awready && !bvalid) begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      bresp <= wr_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      enable <= 1'b0;
    end else if (aw_hs && awaddr == KBD_REG_CTRL && wstrb[0]) begin
      enable <= wdata[0];
    end
  end

  // read channel: one address at a time, rvalid held until rready
  always_ff @(posedge clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= 1'b0;
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (ar_hs) begin
        rvalid <= 1'b1;
      end else if (arvalid && !arready && !rvalid) begin
        arready <= 1'b1;
      end
    end
  end

  // read mux, sampled on the accepting edge
  always_comb begin
    rd_word = '0;
    rd_ok   = 1'b1;
    case (araddr)
      KBD_REG_DATA: begin
        // empty fifo reads as all zeros
        if (!fifo.empty) begin
          rd_word[AXI_DATA_W-1]          = 1'b1;
          rd_word[$bits(kbd_event_t)-1:0] = fifo.rd_data;
        end
      end
      KBD_REG_STATUS: begin
        rd_word[8]                 = fifo.empty;
        rd_word[FIFO_DEPTH_LOG2:0] = fifo.level;
      end
      KBD_REG_CTRL:   rd_word[0] = enable;
      KBD_REG_ERRCNT: rd_word    = err_cnt;
      default:        rd_ok      = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata <= rd_word;
      rresp <= rd_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
  end

  // head leaves the fifo on the edge that latches it into rdata
  assign fifo.pop = ar_hs && (araddr == KBD_REG_DATA) && !fifo.empty;

  // count errored events as the core takes them, clear wins
  always_ff @(posedge clk) begin
    if (rst || err_clear) begin
      err_cnt <= '0;
    end else if (fifo.pop && fifo.rd_data.error) begin
      err_cnt <= err_cnt + 1'b1;
    end
  end

  a_bvalid_hold: assert property (
    @(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp)
  );

  a_rvalid_hold: assert property (
    @(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
  );

endmodule

`default_nettype wire

// ==== hw/kbd_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module kbd_ctrl
  import kbd_pkg::*;
#(
  parameter int FIFO_DEPTH_LOG2 = 4
) (
  // ps/2 line
  input  logic                  kbd_clk,
  input  logic                  kbd_data,
  // core clock and reset
  input  logic                  core_clk,
  input  logic                  rst,
  // axi4-lite slave
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic [3:0]            wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [AXI_DATA_W-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready
);

  // keyboard domain, receiver to fifo
  logic       push;
  kbd_event_t push_data;
  logic       full;
  // core domain, register block to receiver
  logic       enable;

  kbd_fifo_rd_if #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) rd_if ();

  kbd_frame_rx frame_rx0 (
    .kbd_clk   (kbd_clk),
    .rst       (rst),
    .kbd_data  (kbd_data),
    .enable    (enable),
    .push      (push),
    .push_data (push_data),
    .full      (full)
  );

  // events cross from kbd_clk to core_clk here
  kbd_gray_fifo #(
    .payload_t       (kbd_event_t),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) fifo0 (
    .wr_clk    (kbd_clk),
    .rst       (rst),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .rd_clk    (core_clk),
    .rd        (rd_if.fifo)
  );

  kbd_axil_regs #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) regs0 (
    .clk     (core_clk),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .fifo    (rd_if.ctrl),
    .enable  (enable)
  );

endmodule

`default_nettype wire

// ==== sim/kbd_tb_tasks.svh ====
// sends one 11-bit frame of start bit, data lsb first, odd parity and stop bit
// idle cycles up front also cover the enable synchronizer
task automatic send_frame(input logic [7:0] code, input logic bad_parity,
                          input logic bad_stop);
  logic [10:0] bits;
  bits = {~bad_stop, ~(^code) ^ bad_parity, code, 1'b0};
  repeat (3) begin
    @(negedge kbd_clk);
    kbd_data = 1'b1;
  end
  for (int i = 0; i < 11; i++) begin
    @(negedge kbd_clk);
    kbd_data = bits[i];
  end
  @(negedge kbd_clk);
  kbd_data = 1'b1;
endtask

task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                         output logic [1:0] resp);
  int cnt;
  @(negedge core_clk);
  awaddr  = addr;
  awvalid = 1'b1;
  wdata   = data;
  wstrb   = 4'hF;
  wvalid  = 1'b1;
  bready  = 1'b0;
  cnt     = 0;
  @(negedge core_clk);
  while (!(awready === 1'b1 && wready === 1'b1) && cnt < AXI_TIMEOUT) begin
    @(negedge core_clk);
    cnt++;
  end
  if (awready !== 1'b1 || wready !== 1'b1) begin
    fail_msg("write address and data were never accepted");
  end
  // handshake on the rising edge in between
  @(negedge core_clk);
  awvalid = 1'b0;
  wvalid  = 1'b0;
  cnt     = 0;
  while (bvalid !== 1'b1 && cnt < AXI_TIMEOUT) begin
    @(negedge core_clk);
    cnt++;
  end
  if (bvalid !== 1'b1) begin
    fail_msg("write response never arrived");
  end
  resp = bresp;
  // bready stays low for one cycle so the response has to hold
  @(negedge core_clk);
  assert (bvalid === 1'b1) else fail_mismatch("bvalid", 32'h1, bvalid);
  assert (bresp === resp) else fail_mismatch("bresp", resp, bresp);
  bready = 1'b1;
  @(negedge core_clk);
  bready = 1'b0;
endtask

// stall holds rready low for that many cycles once rvalid is up
task automatic axi_read(input logic [3:0] addr, input int stall,
                        output logic [31:0] data, output logic [1:0] resp);
  int cnt;
  @(negedge core_clk);
  araddr  = addr;
  arvalid = 1'b1;
  rready  = (stall == 0);
  cnt     = 0;
  @(negedge core_clk);
  while (arready !== 1'b1 && cnt < AXI_TIMEOUT) begin
    @(negedge core_clk);
    cnt++;
  end
  if (arready !== 1'b1) begin
    fail_msg("read address was never accepted");
  end
  @(negedge core_clk);
  arvalid = 1'b0;
  cnt     = 0;
  while (rvalid !== 1'b1 && cnt < AXI_TIMEOUT) begin
    @(negedge core_clk);
    cnt++;
  end
  if (rvalid !== 1'b1) begin
    fail_msg("read data never arrived");
  end
  data = rdata;
  resp = rresp;
  // response must hold still while the master stalls
  for (int i = 0; i < stall; i++) begin
    @(negedge core_clk);
    assert (rvalid === 1'b1) else fail_mismatch("rvalid", 32'h1, rvalid);
    assert (rdata === data) else fail_mismatch("rdata", data, rdata);
  end
  rready = 1'b1;
  @(negedge core_clk);
  rready = 1'b0;
endtask

task automatic check_read(input logic [3:0] addr, input logic [31:0] exp_data,
                          input logic [1:0] exp_resp);
  logic [31:0] data;
  logic [1:0]  resp;
  axi_read(addr, 0, data, resp);
  assert (resp === exp_resp) else fail_mismatch("rresp", exp_resp, resp);
  // SLVERR carries no defined data
  if (exp_resp == AXI_RESP_OKAY) begin
    assert (data === exp_data) else fail_mismatch("rdata", exp_data, data);
  end
endtask

task automatic check_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
  logic [1:0] resp;
  axi_write(addr, data, resp);
  assert (resp === exp_resp) else fail_mismatch("bresp", exp_resp, resp);
endtask

// poll STATUS until the level settles after the pointer crossing
task automatic wait_level(input int n);
  logic [31:0] data;
  logic [1:0]  resp;
  int          polls;
  polls = 0;
  axi_read(KBD_REG_STATUS, 0, data, resp);
  while (data !== status_word(n) && polls < POLL_LIMIT) begin
    axi_read(KBD_REG_STATUS, 0, data, resp);
    polls++;
  end
  if (data !== status_word(n)) begin
    fail_msg($sformatf("fifo level never reached %0d", n));
  end
endtask

// ==== sim/kbd_ctrl_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module kbd_ctrl_tb
  import kbd_pkg::*;
();

  localparam int FIFO_DEPTH_LOG2 = 4;
  localparam int FIFO_DEPTH      = 1 << FIFO_DEPTH_LOG2;
  localparam int AXI_TIMEOUT     = 20;
  localparam int POLL_LIMIT      = 100;

  logic                  core_clk;
  logic                  kbd_clk;
  logic                  rst;
  logic                  kbd_data;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [AXI_DATA_W-1:0] wdata;
  logic [3:0]            wstrb;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [AXI_DATA_W-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;

  // model state
  logic [31:0] lcg_state;
  logic        rx_enabled;
  int          err_popped;
  kbd_event_t  exp_q[$];
  // scratch for the main sequence
  logic [31:0] r;
  logic [31:0] rd_val;
  logic [1:0]  rd_resp;
  kbd_event_t  ev;
  int          stall;

  kbd_ctrl #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) dut0 (.*);

  always #50 core_clk = ~core_clk;

  // first rising edge at 300 ns falls inside reset and the period is 1200 ns
  always begin
    #300;
    kbd_clk = 1'b1;
    #600;
    kbd_clk = 1'b0;
    #300;
  end

  `include "kbd_tb_tasks.svh"

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic fail_msg(input string what);
    $display("%0t ns: %s", $time, what);
    abort_run();
  endtask

  task automatic fail_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("[FAIL] %0t ns: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
    abort_run();
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [7:0] random_code();
    logic [31:0] v;
    logic [7:0]  c;
    v = lcg_next();
    c = v[23:16];
    // a prefix value would open a new sequence
    if (c == KBD_PREFIX_EXT || c == KBD_PREFIX_REL) begin
      c = c ^ 8'h01;
    end
    return c;
  endfunction

  // empty flag in bit 8 and level in the low bits
  function automatic logic [31:0] status_word(input int n);
    return (n == 0) ? 32'h0000_0100 : 32'(n);
  endfunction

  // valid in bit 31 and event in bits 10:0
  function automatic logic [31:0] data_word(input kbd_event_t e);
    return {1'b1, 20'b0, e};
  endfunction

  // frames sent while disabled or into a full fifo are lost
  task automatic predict(input kbd_event_t e);
    if (rx_enabled && exp_q.size() < FIFO_DEPTH) begin
      exp_q.push_back(e);
    end
  endtask

  task automatic send_key(input logic [7:0] code, input logic ext, input logic rel);
    kbd_event_t key_ev;
    if (ext) begin
      send_frame(KBD_PREFIX_EXT, 1'b0, 1'b0);
    end
    if (rel) begin
      send_frame(KBD_PREFIX_REL, 1'b0, 1'b0);
    end
    send_frame(code, 1'b0, 1'b0);
    key_ev.code     = code;
    key_ev.extended = ext;
    key_ev.released = rel;
    key_ev.error    = 1'b0;
    predict(key_ev);
  endtask

  // errored frames keep the raw byte and drop any prefix
  task automatic send_bad(input logic [7:0] code, input logic bad_parity,
                          input logic bad_stop);
    kbd_event_t bad_ev;
    send_frame(code, bad_parity, bad_stop);
    bad_ev.code     = code;
    bad_ev.extended = 1'b0;
    bad_ev.released = 1'b0;
    bad_ev.error    = 1'b1;
    predict(bad_ev);
  endtask

  task automatic pop_expect();
    kbd_event_t exp_ev;
    exp_ev = exp_q.pop_front();
    check_read(KBD_REG_DATA, data_word(exp_ev), AXI_RESP_OKAY);
    if (exp_ev.error) begin
      err_popped++;
    end
  endtask

  // wait for every predicted event and pop them with the level counting down
  task automatic drain_check();
    wait_level(exp_q.size());
    while (exp_q.size() > 0) begin
      check_read(KBD_REG_STATUS, status_word(exp_q.size()), AXI_RESP_OKAY);
      pop_expect();
    end
    check_read(KBD_REG_DATA, 32'h0, AXI_RESP_OKAY);
  endtask

  initial begin
    core_clk   = 1'b0;
    kbd_clk    = 1'b0;
    rst        = 1'b1;
    kbd_data   = 1'b1;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    lcg_state  = 32'haf78_a0aa;
    rx_enabled = 1'b0;
    err_popped = 0;
    repeat (4) @(posedge core_clk);
    @(negedge core_clk);
    rst = 1'b0;
    // keyboard side leaves reset a few kbd_clk edges later
    repeat (4) @(negedge kbd_clk);

    // reset values and bus errors that change nothing
    check_read(KBD_REG_CTRL, 32'h0, AXI_RESP_OKAY);
    check_read(KBD_REG_STATUS, status_word(0), AXI_RESP_OKAY);
    check_read(KBD_REG_DATA, 32'h0, AXI_RESP_OKAY);
    check_write(KBD_REG_STATUS, 32'h1, AXI_RESP_SLVERR);
    check_write(KBD_REG_DATA, 32'h1, AXI_RESP_SLVERR);
    // unaligned offset outside the map
    check_read(4'h2, 32'h0, AXI_RESP_SLVERR);
    check_read(KBD_REG_CTRL, 32'h0, AXI_RESP_OKAY);

    // receiver off so the frame must not show up
    send_key(random_code(), 1'b0, 1'b0);
    repeat (10) check_read(KBD_REG_STATUS, status_word(0), AXI_RESP_OKAY);
    check_write(KBD_REG_CTRL, 32'h1, AXI_RESP_OKAY);
    rx_enabled = 1'b1;
    check_read(KBD_REG_CTRL, 32'h1, AXI_RESP_OKAY);

    // plain, E0, F0 and E0 F0 sequences twice each with random codes
    for (int i = 0; i < 8; i++) begin
      send_key(random_code(), i[0], i[1]);
    end
    drain_check();

    // parity error, stop error and an error after a pending prefix
    send_bad(random_code(), 1'b1, 1'b0);
    send_bad(random_code(), 1'b0, 1'b1);
    send_frame(KBD_PREFIX_EXT, 1'b0, 1'b0);
    send_bad(random_code(), 1'b1, 1'b0);
    send_key(random_code(), 1'b0, 1'b0);
    drain_check();
    check_read(KBD_REG_ERRCNT, 32'(err_popped), AXI_RESP_OKAY);
    // any written value clears the count
    check_write(KBD_REG_ERRCNT, 32'hFFFF_FFFF, AXI_RESP_OKAY);
    err_popped = 0;
    check_read(KBD_REG_ERRCNT, 32'h0, AXI_RESP_OKAY);

    // only the first FIFO_DEPTH events survive an overflow
    for (int i = 0; i < 20; i++) begin
      send_key(random_code(), 1'b0, 1'b0);
    end
    drain_check();

    // read back-pressure pops exactly one event
    for (int i = 0; i < 3; i++) begin
      send_key(random_code(), 1'b0, 1'b0);
    end
    wait_level(3);
    r     = lcg_next();
    stall = 1 + int'(r[18:16]);
    ev    = exp_q.pop_front();
    axi_read(KBD_REG_DATA, stall, rd_val, rd_resp);
    assert (rd_resp === AXI_RESP_OKAY) else fail_mismatch("rresp", AXI_RESP_OKAY, rd_resp);
    assert (rd_val === data_word(ev)) else fail_mismatch("rdata", data_word(ev), rd_val);
    drain_check();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== kbd_ctrl.f ====
+incdir+sim
hw/kbd_pkg.sv
hw/kbd_fifo_rd_if.sv
hw/kbd_frame_rx.sv
hw/kbd_gray_fifo.sv
hw/kbd_axil_regs.sv
hw/kbd_ctrl.sv
sim/kbd_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: kbd_ctrl

sources:
  - files:
      - hw/kbd_pkg.sv
      - hw/kbd_fifo_rd_if.sv
      - hw/kbd_frame_rx.sv
      - hw/kbd_gray_fifo.sv
      - hw/kbd_axil_regs.sv
      - hw/kbd_ctrl.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/kbd_ctrl_tb.sv
